// File: logic/vec_pkg.sv
//////////////////////////////
// Vector coprocessor package
// Sizes, element types, opcodes and the
// structs shared between the blocks
//////////////////////////////

package vec_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  localparam int unsigned NrLanes      = 2;
  localparam int unsigned NrVRegs      = 8;
  localparam int unsigned VLen         = 8;
  // Element i sits in lane i mod NrLanes, row i div NrLanes
  localparam int unsigned ElemsPerLane = VLen / NrLanes;
  localparam int unsigned ElemWidth    = 16;
  // Outstanding instructions and dispatcher depth
  localparam int unsigned QueueDepth   = 4;

  //////////////////////////////
  // Plain vector types
  //////////////////////////////

  typedef logic [ElemWidth-1:0]              elem_t;
  typedef logic [$clog2(NrVRegs)-1:0]        vreg_t;
  typedef logic [$clog2(ElemsPerLane)-1:0]   row_t;
  typedef logic [$clog2(NrLanes)-1:0]        lane_t;
  // Global element index inside one vector
  typedef logic [$clog2(VLen)-1:0]           eidx_t;
  typedef logic [$clog2(QueueDepth)-1:0]     qptr_t;
  typedef logic [$clog2(QueueDepth):0]       qcnt_t;

  //////////////////////////////
  // Instructions and requests
  //////////////////////////////

  typedef enum logic [1:0] {
    op_add_vv,
    op_add_vx,
    op_slide1up,
    op_ext_xv
  } vec_op_e;

  // For op_ext_xv the low bits of scalar hold the element index
  typedef struct packed {
    vec_op_e op;
    vreg_t   vd;
    vreg_t   vs1;
    vreg_t   vs2;
    elem_t   scalar;
  } vec_insn_t;

  typedef struct packed {
    elem_t data;
  } vec_resp_t;

  typedef struct packed {
    vreg_t vd;
    row_t  row;
    elem_t data;
  } vrf_wreq_t;

  typedef struct packed {
    vreg_t vreg;
    row_t  row;
  } vrf_rreq_t;

  typedef enum logic {
    unit_alu,
    unit_slide
  } unit_e;

endpackage

// File: logic/vec_dispatcher.sv
//////////////////////////////
// Instruction dispatcher
// Circular queue of instructions strobed in by
// the scalar core, head offered to the sequencer
//////////////////////////////

`timescale 1ns/1ps

module vec_dispatcher (
  input  logic               clk_i,
  input  logic               reset_i,
  // Scalar core side
  input  logic               req_valid_i,
  input  vec_pkg::vec_insn_t req_i,
  // Sequencer side
  output logic               head_valid_o,
  output vec_pkg::vec_insn_t head_o,
  input  logic               pop_i
);

  import vec_pkg::*;

  vec_insn_t queue_q [QueueDepth];
  qptr_t     rd_ptr_q;
  qptr_t     wr_ptr_q;
  qcnt_t     count_q;

  assign head_valid_o = (count_q != '0);
  assign head_o       = queue_q[rd_ptr_q];

  // Pointers and fill level
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (req_valid_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({req_valid_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage, the core never overfills it
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      queue_q[wr_ptr_q] <= req_i;
    end
  end

endmodule

// File: logic/vec_sequencer.sv
//////////////////////////////
// Vector sequencer
// Checks register hazards, issues to the ALU or
// slide unit and retires responses in order
//////////////////////////////

`timescale 1ns/1ps

module vec_sequencer (
  input  logic                                    clk_i,
  input  logic                                    reset_i,
  // Dispatcher side
  input  logic                                    head_valid_i,
  input  vec_pkg::vec_insn_t                      head_i,
  output logic                                    pop_o,
  // Processing units
  output logic                                    alu_start_o,
  output logic                                    slide_start_o,
  output vec_pkg::vec_insn_t                      insn_o,
  input  logic               [vec_pkg::NrLanes-1:0] alu_done_i,
  input  logic               [vec_pkg::NrLanes-1:0] ext_valid_i,
  input  vec_pkg::elem_t     [vec_pkg::NrLanes-1:0] ext_data_i,
  input  logic                                    slide_done_i,
  // Responses to the core
  output logic                                    resp_valid_o,
  output vec_pkg::vec_resp_t                      resp_o
);

  import vec_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_busy,
    st_finished
  } unit_state_e;

  unit_state_e        state_q [2];
  vec_insn_t          insn_q  [2];
  logic [NrLanes-1:0] lane_done_q;
  elem_t              ext_data_q;
  unit_e              oldest_q;

  unit_e              head_unit;
  unit_e              other_old;
  unit_e              other_head;
  logic               hazard;
  logic               issue;
  logic [1:0]         finish;
  logic               retire;
  elem_t              ext_data_sel;

  function automatic logic writes_vd(vec_insn_t insn);
    return insn.op != op_ext_xv;
  endfunction

  function automatic logic reads_reg(vec_insn_t insn, vreg_t vreg);
    return (insn.vs2 == vreg) || ((insn.op == op_add_vv) && (insn.vs1 == vreg));
  endfunction

  //////////////////////////////
  // Hazard check and issue
  //////////////////////////////

  always_comb begin
    head_unit  = (head_i.op == op_slide1up) ? unit_slide : unit_alu;
    other_head = (head_unit == unit_alu) ? unit_slide : unit_alu;
    other_old  = (oldest_q == unit_alu) ? unit_slide : unit_alu;
    hazard     = 1'b0;
    // Only running instructions still touch the register file
    for (int u = 0; u < 2; u++) begin
      if (state_q[u] == st_busy) begin
        hazard = hazard
               | (writes_vd(insn_q[u]) && reads_reg(head_i, insn_q[u].vd))
               | (writes_vd(insn_q[u]) && writes_vd(head_i) && (insn_q[u].vd == head_i.vd))
               | (writes_vd(head_i) && reads_reg(insn_q[u], head_i.vd));
      end
    end
    issue = head_valid_i && (state_q[head_unit] == st_idle) && !hazard;
  end

  assign pop_o         = issue;
  assign alu_start_o   = issue && (head_unit == unit_alu);
  assign slide_start_o = issue && (head_unit == unit_slide);
  assign insn_o        = head_i;

  //////////////////////////////
  // Completion and retirement
  //////////////////////////////

  always_comb begin
    ext_data_sel = '0;
    for (int l = 0; l < NrLanes; l++) begin
      if (ext_valid_i[l]) begin
        ext_data_sel = ext_data_i[l];
      end
    end
    // Lanes may finish on different cycles
    finish[unit_alu]   = (state_q[unit_alu] == st_busy) && (&(lane_done_q | alu_done_i));
    finish[unit_slide] = (state_q[unit_slide] == st_busy) && slide_done_i;
    retire             = (state_q[oldest_q] == st_finished);
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int u = 0; u < 2; u++) begin
        state_q[u] <= st_idle;
      end
      lane_done_q  <= '0;
      oldest_q     <= unit_alu;
      resp_valid_o <= 1'b0;
    end else begin
      for (int u = 0; u < 2; u++) begin
        if (issue && (head_unit == unit_e'(u))) begin
          state_q[u] <= st_busy;
        end else if (finish[u]) begin
          state_q[u] <= st_finished;
        end else if (retire && (oldest_q == unit_e'(u))) begin
          state_q[u] <= st_idle;
        end
      end
      lane_done_q <= finish[unit_alu] ? '0 : (lane_done_q | alu_done_i);
      // Age order of the two units
      if (retire) begin
        if (state_q[other_old] != st_idle) begin
          oldest_q <= other_old;
        end else if (issue) begin
          oldest_q <= head_unit;
        end
      end else if (issue && (state_q[other_head] == st_idle)) begin
        oldest_q <= head_unit;
      end
      resp_valid_o <= retire;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue) begin
      insn_q[head_unit] <= head_i;
    end
    if (|ext_valid_i) begin
      ext_data_q <= ext_data_sel;
    end
    // Only extraction returns data
    resp_o.data <= (insn_q[oldest_q].op == op_ext_xv) ? ext_data_q : '0;
  end

endmodule

// File: logic/vec_lane.sv
//////////////////////////////
// Vector lane
// One slice of the register file with an ALU
// port and a slide read port, plus the adder
//////////////////////////////

`timescale 1ns/1ps

module vec_lane (
  input  logic               clk_i,
  input  logic               reset_i,
  input  vec_pkg::lane_t     lane_id_i,
  // Sequencer side
  input  logic               start_i,
  input  vec_pkg::vec_insn_t insn_i,
  output logic               done_o,
  output logic               ext_valid_o,
  output vec_pkg::elem_t     ext_data_o,
  // Write port through the arbiter
  output vec_pkg::vrf_wreq_t alu_wreq_o,
  output logic               alu_wvalid_o,
  input  vec_pkg::vrf_wreq_t wreq_i,
  input  logic               wvalid_i,
  input  logic               alu_gnt_i,
  // Slide unit read port
  input  vec_pkg::vrf_rreq_t slide_rreq_i,
  output vec_pkg::elem_t     slide_rdata_o
);

  import vec_pkg::*;

  elem_t     vrf_q [NrVRegs][ElemsPerLane];
  logic      busy_q;
  vec_insn_t insn_q;
  row_t      row_q;

  elem_t     op_a;
  elem_t     op_b;
  eidx_t     ext_idx;
  lane_t     ext_lane;
  row_t      ext_row;

  // Owner of the extracted element
  assign ext_idx  = insn_i.scalar[$bits(eidx_t)-1:0];
  assign ext_lane = lane_t'(ext_idx % NrLanes);
  assign ext_row  = row_t'(ext_idx / NrLanes);

  //////////////////////////////
  // ALU datapath
  //////////////////////////////

  assign op_a = vrf_q[insn_q.vs2][row_q];
  assign op_b = (insn_q.op == op_add_vv) ? vrf_q[insn_q.vs1][row_q] : insn_q.scalar;

  assign alu_wvalid_o    = busy_q;
  assign alu_wreq_o.vd   = insn_q.vd;
  assign alu_wreq_o.row  = row_q;
  assign alu_wreq_o.data = op_a + op_b;

  assign slide_rdata_o = vrf_q[slide_rreq_i.vreg][slide_rreq_i.row];

  // Row counter steps only on grant
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q      <= 1'b0;
      row_q       <= '0;
      done_o      <= 1'b0;
      ext_valid_o <= 1'b0;
    end else begin
      done_o      <= 1'b0;
      ext_valid_o <= 1'b0;
      if (start_i) begin
        if (insn_i.op == op_ext_xv) begin
          done_o      <= 1'b1;
          ext_valid_o <= (ext_lane == lane_id_i);
        end else begin
          busy_q <= 1'b1;
          row_q  <= '0;
        end
      end else if (busy_q && alu_gnt_i) begin
        row_q <= row_q + 1'b1;
        if (row_q == row_t'(ElemsPerLane - 1)) begin
          busy_q <= 1'b0;
          done_o <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      insn_q     <= insn_i;
      ext_data_o <= vrf_q[insn_i.vs2][ext_row];
    end
  end

  //////////////////////////////
  // Register file slice
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int r = 0; r < NrVRegs; r++) begin
        for (int e = 0; e < ElemsPerLane; e++) begin
          vrf_q[r][e] <= '0;
        end
      end
    end else if (wvalid_i) begin
      vrf_q[wreq_i.vd][wreq_i.row] <= wreq_i.data;
    end
  end

endmodule

// File: logic/vrf_write_arbiter.sv
//////////////////////////////
// Register file write arbiter
// Round-robin between lane ALU and slide unit
//////////////////////////////

`timescale 1ns/1ps

module vrf_write_arbiter (
  input  logic               clk_i,
  input  logic               reset_i,
  input  vec_pkg::vrf_wreq_t alu_req_i,
  input  logic               alu_valid_i,
  input  vec_pkg::vrf_wreq_t slide_req_i,
  input  logic               slide_valid_i,
  output logic               alu_gnt_o,
  output logic               slide_gnt_o,
  output vec_pkg::vrf_wreq_t wreq_o,
  output logic               wvalid_o
);

  import vec_pkg::*;

  unit_e last_q;

  // On contention the previous loser wins
  always_comb begin
    alu_gnt_o   = alu_valid_i;
    slide_gnt_o = slide_valid_i;
    if (alu_valid_i && slide_valid_i) begin
      alu_gnt_o   = (last_q == unit_slide);
      slide_gnt_o = (last_q == unit_alu);
    end
  end

  assign wvalid_o = alu_gnt_o | slide_gnt_o;
  assign wreq_o   = slide_gnt_o ? slide_req_i : alu_req_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      last_q <= unit_alu;
    end else if (slide_gnt_o) begin
      last_q <= unit_slide;
    end else if (alu_gnt_o) begin
      last_q <= unit_alu;
    end
  end

endmodule

// File: logic/slide_unit.sv
//////////////////////////////
// Slide unit
// Slide up by one across the lanes, scalar
// inserted at element 0
//////////////////////////////

`timescale 1ns/1ps

module slide_unit (
  input  logic                                      clk_i,
  input  logic                                      reset_i,
  input  logic                                      start_i,
  input  vec_pkg::vec_insn_t                        insn_i,
  output vec_pkg::vrf_rreq_t [vec_pkg::NrLanes-1:0] rreq_o,
  input  vec_pkg::elem_t     [vec_pkg::NrLanes-1:0] rdata_i,
  output vec_pkg::vrf_wreq_t [vec_pkg::NrLanes-1:0] wreq_o,
  output logic               [vec_pkg::NrLanes-1:0] wvalid_o,
  input  logic               [vec_pkg::NrLanes-1:0] gnt_i,
  output logic                                      done_o
);

  import vec_pkg::*;

  typedef enum logic [1:0] {
    sl_idle,
    sl_read,
    sl_write
  } slide_state_e;

  slide_state_e       state_q;
  vec_insn_t          insn_q;
  row_t               row_q;
  elem_t [NrLanes-1:0] src_q;
  // Last lane's element of the previous row
  elem_t              carry_q;
  logic [NrLanes-1:0] written_q;

  elem_t [NrLanes-1:0] shifted;
  logic               row_done;

  // Each element moves one lane up, lane 0 takes the carry
  assign shifted  = {src_q[NrLanes-2:0], carry_q};
  assign row_done = (state_q == sl_write) && (&(written_q | gnt_i));

  always_comb begin
    for (int l = 0; l < NrLanes; l++) begin
      rreq_o[l].vreg = insn_q.vs2;
      rreq_o[l].row  = row_q;
      wreq_o[l].vd   = insn_q.vd;
      wreq_o[l].row  = row_q;
      wreq_o[l].data = shifted[l];
      wvalid_o[l]    = (state_q == sl_write) && !written_q[l];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q   <= sl_idle;
      row_q     <= '0;
      written_q <= '0;
      done_o    <= 1'b0;
    end else begin
      done_o <= 1'b0;
      case (state_q)
        sl_idle: begin
          if (start_i) begin
            state_q <= sl_read;
            row_q   <= '0;
          end
        end
        sl_read: state_q <= sl_write;
        sl_write: begin
          if (row_done) begin
            written_q <= '0;
            if (row_q == row_t'(ElemsPerLane - 1)) begin
              state_q <= sl_idle;
              done_o  <= 1'b1;
            end else begin
              row_q   <= row_q + 1'b1;
              state_q <= sl_read;
            end
          end else begin
            // Keep halves already granted
            written_q <= written_q | gnt_i;
          end
        end
        default: state_q <= sl_idle;
      endcase
    end
  end

  // Source row is captured before any of it is overwritten
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      insn_q  <= insn_i;
      carry_q <= insn_i.scalar;
    end else if (row_done) begin
      carry_q <= src_q[NrLanes-1];
    end
    if (state_q == sl_read) begin
      src_q <= rdata_i;
    end
  end

endmodule

// File: logic/vec_unit.sv
//////////////////////////////
// Vector coprocessor top
// Dispatcher, sequencer, lanes with their write
// arbiters and the slide unit
//////////////////////////////

`timescale 1ns/1ps

module vec_unit (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               req_valid_i,
  input  vec_pkg::vec_insn_t req_i,
  output logic               resp_valid_o,
  output vec_pkg::vec_resp_t resp_o
);

  import vec_pkg::*;

  //////////////////////////////
  // Dispatcher and sequencer
  //////////////////////////////

  logic                head_valid;
  vec_insn_t           head;
  logic                pop;
  logic                alu_start;
  logic                slide_start;
  vec_insn_t           insn;
  logic [NrLanes-1:0]  alu_done;
  logic [NrLanes-1:0]  ext_valid;
  elem_t [NrLanes-1:0] ext_data;
  logic                slide_done;

  vec_dispatcher i_dispatcher (
    .clk_i        (clk_i      ),
    .reset_i      (reset_i    ),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i      ),
    .head_valid_o (head_valid ),
    .head_o       (head       ),
    .pop_i        (pop        )
  );

  vec_sequencer i_sequencer (
    .clk_i         (clk_i       ),
    .reset_i       (reset_i     ),
    .head_valid_i  (head_valid  ),
    .head_i        (head        ),
    .pop_o         (pop         ),
    .alu_start_o   (alu_start   ),
    .slide_start_o (slide_start ),
    .insn_o        (insn        ),
    .alu_done_i    (alu_done    ),
    .ext_valid_i   (ext_valid   ),
    .ext_data_i    (ext_data    ),
    .slide_done_i  (slide_done  ),
    .resp_valid_o  (resp_valid_o),
    .resp_o        (resp_o      )
  );

  //////////////////////////////
  // Slide unit
  //////////////////////////////

  vrf_rreq_t [NrLanes-1:0] slide_rreq;
  elem_t     [NrLanes-1:0] slide_rdata;
  vrf_wreq_t [NrLanes-1:0] slide_wreq;
  logic      [NrLanes-1:0] slide_wvalid;
  logic      [NrLanes-1:0] slide_gnt;

  slide_unit i_slide_unit (
    .clk_i    (clk_i       ),
    .reset_i  (reset_i     ),
    .start_i  (slide_start ),
    .insn_i   (insn        ),
    .rreq_o   (slide_rreq  ),
    .rdata_i  (slide_rdata ),
    .wreq_o   (slide_wreq  ),
    .wvalid_o (slide_wvalid),
    .gnt_i    (slide_gnt   ),
    .done_o   (slide_done  )
  );

  //////////////////////////////
  // Lanes
  //////////////////////////////

  vrf_wreq_t [NrLanes-1:0] alu_wreq;
  logic      [NrLanes-1:0] alu_wvalid;
  logic      [NrLanes-1:0] alu_gnt;
  vrf_wreq_t [NrLanes-1:0] wreq;
  logic      [NrLanes-1:0] wvalid;

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lanes
    vec_lane i_lane (
      .clk_i         (clk_i         ),
      .reset_i       (reset_i       ),
      .lane_id_i     (lane_t'(l)    ),
      .start_i       (alu_start     ),
      .insn_i        (insn          ),
      .done_o        (alu_done[l]   ),
      .ext_valid_o   (ext_valid[l]  ),
      .ext_data_o    (ext_data[l]   ),
      .alu_wreq_o    (alu_wreq[l]   ),
      .alu_wvalid_o  (alu_wvalid[l] ),
      .wreq_i        (wreq[l]       ),
      .wvalid_i      (wvalid[l]     ),
      .alu_gnt_i     (alu_gnt[l]    ),
      .slide_rreq_i  (slide_rreq[l] ),
      .slide_rdata_o (slide_rdata[l])
    );

    vrf_write_arbiter i_arbiter (
      .clk_i         (clk_i          ),
      .reset_i       (reset_i        ),
      .alu_req_i     (alu_wreq[l]    ),
      .alu_valid_i   (alu_wvalid[l]  ),
      .slide_req_i   (slide_wreq[l]  ),
      .slide_valid_i (slide_wvalid[l]),
      .alu_gnt_o     (alu_gnt[l]     ),
      .slide_gnt_o   (slide_gnt[l]   ),
      .wreq_o        (wreq[l]        ),
      .wvalid_o      (wvalid[l]      )
    );
  end : gen_lanes

endmodule

// File: tests/vec_ref_model.svh
//////////////////////////////
// Vector coprocessor reference model
// Register file image and expected responses,
// updated in program order at issue
//////////////////////////////

`ifndef VEC_REF_MODEL_SVH
`define VEC_REF_MODEL_SVH

// Whole vectors, element i at index i
elem_t model_vrf [NrVRegs][VLen];
// One expected response per instruction, in issue order
elem_t exp_resp [$];

task automatic model_reset();
  for (int r = 0; r < NrVRegs; r++) begin
    for (int i = 0; i < VLen; i++) begin
      model_vrf[r][i] = '0;
    end
  end
  exp_resp.delete();
endtask

task automatic model_apply(vec_insn_t insn);
  elem_t src   [VLen];
  elem_t other [VLen];
  elem_t result;
  // Sources copied first so that vd may equal vs1 or vs2
  for (int i = 0; i < VLen; i++) begin
    src[i]   = model_vrf[insn.vs2][i];
    other[i] = model_vrf[insn.vs1][i];
  end
  result = '0;
  case (insn.op)
    op_add_vv: begin
      for (int i = 0; i < VLen; i++) begin
        model_vrf[insn.vd][i] = src[i] + other[i];
      end
    end
    op_add_vx: begin
      for (int i = 0; i < VLen; i++) begin
        model_vrf[insn.vd][i] = src[i] + insn.scalar;
      end
    end
    op_slide1up: begin
      // Scalar enters at element 0, last source element is lost
      model_vrf[insn.vd][0] = insn.scalar;
      for (int i = 1; i < VLen; i++) begin
        model_vrf[insn.vd][i] = src[i-1];
      end
    end
    default: begin
      result = src[insn.scalar % VLen];
    end
  endcase
  exp_resp.push_back(result);
endtask

`endif

// File: tests/tb_vec_unit.sv
//////////////////////////////
// Vector coprocessor testbench
// Random instruction stream from the core side,
// responses checked against a reference model
//////////////////////////////

`timescale 1ns/1ps

module tb_vec_unit;

  import vec_pkg::*;

  localparam int unsigned NrMixInsns = 400;
  localparam int unsigned WaitCycles = 1000;

  logic      clk;
  logic      reset;
  logic      req_valid;
  vec_insn_t req;
  logic      resp_valid;
  vec_resp_t resp;

  // Counted by the driver and the monitor respectively
  int unsigned issued_cnt = 0;
  int unsigned resp_cnt = 0;

  `include "vec_ref_model.svh"

  vec_unit DUT (
    .clk_i        (clk       ),
    .reset_i      (reset     ),
    .req_valid_i  (req_valid ),
    .req_i        (req       ),
    .resp_valid_o (resp_valid),
    .resp_o       (resp      )
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic abort_run(string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1);
  endtask

  function automatic vec_insn_t make_insn(vec_op_e op, vreg_t vd, vreg_t vs1, vreg_t vs2,
                                          elem_t scalar);
    vec_insn_t insn;
    insn.op     = op;
    insn.vd     = vd;
    insn.vs1    = vs1;
    insn.vs2    = vs2;
    insn.scalar = scalar;
    return insn;
  endfunction

  function automatic vreg_t rand_reg();
    return vreg_t'($urandom_range(0, NrVRegs - 1));
  endfunction

  function automatic elem_t rand_elem();
    return elem_t'($urandom);
  endfunction

  // Adds and slides dominate so the write ports see contention
  function automatic vec_insn_t rand_insn();
    int unsigned pick;
    vec_op_e     op;
    pick = $urandom_range(0, 9);
    if (pick < 3) begin
      op = op_add_vv;
    end else if (pick < 6) begin
      op = op_add_vx;
    end else if (pick < 9) begin
      op = op_slide1up;
    end else begin
      op = op_ext_xv;
    end
    return make_insn(op, rand_reg(), rand_reg(), rand_reg(), rand_elem());
  endfunction

  // Strobe one instruction once a slot is free
  task automatic send(vec_insn_t insn);
    int unsigned cycles;
    cycles = 0;
    while (issued_cnt - resp_cnt >= QueueDepth) begin
      @(posedge clk);
      #1;
      cycles++;
      assert (cycles < WaitCycles)
        else abort_run("timed out waiting for a free instruction slot");
    end
    req_valid = 1'b1;
    req       = insn;
    model_apply(insn);
    issued_cnt++;
    @(posedge clk);
    #1;
    req_valid = 1'b0;
  endtask

  task automatic drain(string phase);
    int unsigned cycles;
    cycles = 0;
    while (resp_cnt != issued_cnt) begin
      @(posedge clk);
      #1;
      cycles++;
      assert (cycles < WaitCycles)
        else abort_run($sformatf("timed out waiting for the responses of the %s phase", phase));
    end
  endtask

  task automatic extract_all(vreg_t vreg);
    for (int i = 0; i < VLen; i++) begin
      send(make_insn(op_ext_xv, '0, '0, vreg, elem_t'(i)));
    end
  endtask

  //////////////////////////////
  // Response monitor
  //////////////////////////////

  always @(negedge clk) begin
    if (!reset && resp_valid) begin
      assert (resp_cnt < issued_cnt)
        else abort_run("a response arrived with no instruction outstanding");
      assert (resp.data == exp_resp[resp_cnt])
        else abort_run($sformatf("mismatch at %0t: resp_o.data expected %h actual %h",
                                 $time, exp_resp[resp_cnt], resp.data));
      resp_cnt++;
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin
    vreg_t vd;
    void'($urandom(32'h07b074ce));
    reset     = 1'b1;
    req_valid = 1'b0;
    req       = '0;
    model_reset();
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;

    // Quiet after reset, then a zeroed register
    repeat (10) begin
      @(posedge clk);
      #1;
      assert (!resp_valid)
        else abort_run($sformatf("mismatch at %0t: resp_valid_o expected 0 actual %b",
                                 $time, resp_valid));
    end
    extract_all(vreg_t'(3));
    drain("reset");

    // Eight slides per register fill it with random elements
    for (int r = 0; r < NrVRegs; r++) begin
      for (int k = 0; k < VLen; k++) begin
        send(make_insn(op_slide1up, vreg_t'(r), '0, vreg_t'(r), rand_elem()));
      end
    end
    drain("fill");

    // Broadcast scalar add
    for (int t = 0; t < 4; t++) begin
      vd = rand_reg();
      send(make_insn(op_add_vx, vd, '0, rand_reg(), rand_elem()));
      send(make_insn(op_ext_xv, '0, '0, vd, rand_elem()));
      send(make_insn(op_ext_xv, '0, '0, vd, rand_elem()));
    end
    drain("scalar add");

    // Register add
    for (int t = 0; t < 4; t++) begin
      vd = rand_reg();
      send(make_insn(op_add_vv, vd, rand_reg(), rand_reg(), rand_elem()));
      extract_all(vd);
    end
    drain("vector add");

    // Slide up
    for (int t = 0; t < 4; t++) begin
      vd = rand_reg();
      send(make_insn(op_slide1up, vd, '0, rand_reg(), rand_elem()));
      extract_all(vd);
    end
    drain("slide");

    // Random mix, then a dump of the whole register file
    for (int n = 0; n < NrMixInsns; n++) begin
      send(rand_insn());
    end
    drain("random mix");
    for (int r = 0; r < NrVRegs; r++) begin
      extract_all(vreg_t'(r));
    end
    drain("register dump");

    $display("No errors");
    $finish;
  end

endmodule

// File: tb.f
+incdir+tests
logic/vec_pkg.sv
logic/vec_dispatcher.sv
logic/vec_sequencer.sv
logic/vec_lane.sv
logic/vrf_write_arbiter.sv
logic/slide_unit.sv
logic/vec_unit.sv
tests/tb_vec_unit.sv

// File: Makefile
# Verilator build and run of the vector coprocessor testbench

SIM = obj_dir/Vtb_vec_unit

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_vec_unit -o Vtb_vec_unit

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir
